//--- common/vdec_pkg.sv
// vector decoder shared definitions
package vdec_pkg;

    localparam int VREG_ADDR_W = 5;
    localparam int VL_W = 5;
    localparam int VSEW_W = 2;
    localparam int GROUP_W = 2;
    localparam int XLEN = 32;
    localparam int IMM_W = 11;

    // element width encoding for 16-bit elements
    localparam logic [VSEW_W-1:0] SEW_16 = 2'd1;

    localparam logic [6:0] V_MAJOR_OP_V = 7'b1010111;

    // funct3 categories
    localparam logic [2:0] V_OPIVV = 3'b000;
    localparam logic [2:0] V_OPMVV = 3'b010;
    localparam logic [2:0] V_OPIVI = 3'b011;
    localparam logic [2:0] V_OPIVX = 3'b100;
    localparam logic [2:0] V_OPMVX = 3'b110;
    localparam logic [2:0] V_OPCFG = 3'b111;

    // funct6 codes
    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VMIN = 6'b000101;
    localparam logic [5:0] F6_VMAX = 6'b000111;
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;
    localparam logic [5:0] F6_VWXUNARY0 = 6'b010000;
    localparam logic [5:0] F6_VMV = 6'b010111;
    localparam logic [5:0] F6_VSADD = 6'b100001;
    localparam logic [5:0] F6_VSLL_VMUL = 6'b100101;
    localparam logic [5:0] F6_VSMUL = 6'b100111;
    localparam logic [5:0] F6_VSRL = 6'b101000;
    localparam logic [5:0] F6_VSRA = 6'b101001;
    localparam logic [5:0] F6_VWREDSUM = 6'b110001;
    localparam logic [5:0] F6_VWMUL = 6'b111011;

    // nine operations need a fourth bit
    typedef enum logic [3:0] {
        PE_ARITH_ADD,
        PE_ARITH_SUB,
        PE_ARITH_AND,
        PE_ARITH_OR,
        PE_ARITH_XOR,
        PE_ARITH_LSHIFT,
        PE_ARITH_RSHIFT_LOG,
        PE_ARITH_RSHIFT_AR,
        PE_ARITH_MUL
    } pe_arith_op_t;

    typedef enum logic [1:0] {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_t;

    typedef enum logic [1:0] {
        PE_SAT_NONE,
        PE_SAT,
        PE_SAT_UPPER
    } pe_saturate_mode_t;

    typedef enum logic [1:0] {
        PE_OP_MODE_RESULT,
        PE_OP_MODE_PASS_MIN,
        PE_OP_MODE_PASS_MAX
    } pe_output_mode_t;

    typedef enum logic {
        VREG_WB_SRC_ARITH,
        VREG_WB_SRC_SCALAR
    } vreg_wb_src_t;

    typedef enum logic {
        APU_RESULT_SRC_VL,
        APU_RESULT_SRC_VS2_0
    } apu_result_src_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic vm;
        logic [VREG_ADDR_W-1:0] vs2;
        logic [VREG_ADDR_W-1:0] vs1;
        logic [2:0] funct3;
        logic [VREG_ADDR_W-1:0] vd;
        logic [6:0] opcode;
    } vinstr_arith_t;

    typedef struct packed {
        logic zero;
        logic [IMM_W-1:0] zimm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vinstr_cfg_t;

    // one word, two views
    typedef union packed {
        vinstr_arith_t arith;
        vinstr_cfg_t cfg;
    } vinstr_u;

    typedef struct packed {
        vinstr_u instr;
        logic [XLEN-1:0] scalar_a;
        logic [XLEN-1:0] scalar_b;
    } apu_req_t;

    typedef struct packed {
        pe_arith_op_t pe_op;
        pe_operand_t operand_select;
        pe_saturate_mode_t saturate_mode;
        pe_output_mode_t output_mode;
        logic widening;
        logic wide_vs1;
        logic unsigned_immediate;
    } pe_ctrl_t;

    typedef struct packed {
        logic vec_reg_write;
        vreg_wb_src_t vd_data_src;
        logic [1:0] elements_to_write;
    } wb_ctrl_t;

    typedef struct packed {
        logic csr_write;
        logic preserve_vl;
        logic set_vl_max;
        apu_result_src_t apu_result_select;
    } cfg_ctrl_t;

    typedef struct packed {
        logic multi_cycle;
        logic fix_vd;
        logic reduction;
    } seq_ctrl_t;

    typedef struct packed {
        logic [VREG_ADDR_W-1:0] vs1;
        logic [VREG_ADDR_W-1:0] vs2;
        logic [VREG_ADDR_W-1:0] vd;
    } vreg_addr_t;

endpackage

//--- hdl/apu_sequencer.sv
// APU handshake sequencer
`timescale 1ns/100ps

module apu_sequencer (
    input  logic clk,
    input  logic n_reset,
    input  logic apu_req_i,
    input  vdec_pkg::apu_req_t apu_data_i,
    input  logic last_cycle_i,
    output logic apu_gnt_o,
    output logic apu_rvalid_o,
    output logic core_halt_o,
    output logic exec_o,
    output vdec_pkg::apu_req_t held_o
);

    typedef enum logic {
        IDLE,
        EXEC
    } seq_state_t;

    seq_state_t state;
    logic accept;

    assign accept = apu_req_i && (state == IDLE);

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (apu_req_i)
                        state <= EXEC;
                end
                EXEC:
                begin
                    // done once the final group has gone out
                    if (last_cycle_i)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // instruction and operands held for the whole execution
    always_ff @(posedge clk)
    begin
        if (accept)
            held_o <= apu_data_i;
    end

    assign apu_gnt_o = (state == IDLE);
    assign exec_o = (state == EXEC);
    assign core_halt_o = (state == EXEC);
    assign apu_rvalid_o = (state == EXEC) && last_cycle_i;

endmodule

//--- decoder/instr_decoder.sv
// vector instruction decoder
`timescale 1ns/100ps

module instr_decoder (
    input  logic exec_i,
    input  vdec_pkg::vinstr_u instr_i,
    output vdec_pkg::pe_ctrl_t pe_ctrl_o,
    output vdec_pkg::wb_ctrl_t wb_ctrl_o,
    output vdec_pkg::cfg_ctrl_t cfg_ctrl_o,
    output vdec_pkg::seq_ctrl_t seq_ctrl_o,
    output logic [vdec_pkg::IMM_W-1:0] immediate_o
);

    logic [2:0] funct3;
    logic [5:0] funct6;
    logic op_v;

    // funct3 and opcode sit in the same place in both views
    assign funct3 = instr_i.arith.funct3;
    assign funct6 = instr_i.arith.funct6;
    assign op_v = (instr_i.arith.opcode == vdec_pkg::V_MAJOR_OP_V);

    always_comb
    begin
        pe_ctrl_o = '0;
        wb_ctrl_o = '0;
        cfg_ctrl_o = '0;
        seq_ctrl_o = '0;
        immediate_o = '0;

        if (exec_i && op_v)
        begin
            if (funct3 == vdec_pkg::V_OPCFG)
            begin
                // vsetvli
                cfg_ctrl_o.csr_write = 1'b1;
                cfg_ctrl_o.apu_result_select = vdec_pkg::APU_RESULT_SRC_VL;
                immediate_o = instr_i.cfg.zimm;
                if (instr_i.cfg.rs1 == '0)
                begin
                    if (instr_i.cfg.rd == '0)
                        cfg_ctrl_o.preserve_vl = 1'b1;
                    else
                        cfg_ctrl_o.set_vl_max = 1'b1;
                end
            end
            else
            begin
                immediate_o = vdec_pkg::IMM_W'(instr_i.arith.vs1);
                wb_ctrl_o.vec_reg_write = 1'b1;

                // second operand follows the funct3 category
                case (funct3)
                    vdec_pkg::V_OPIVX, vdec_pkg::V_OPMVX:
                        pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_SCALAR;
                    vdec_pkg::V_OPIVI:
                        pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_IMMEDIATE;
                    default:
                        pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_VS1;
                endcase

                case (funct6)
                    vdec_pkg::F6_VADD:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_ADD;
                        // vredsum
                        if (funct3 == vdec_pkg::V_OPMVV)
                            pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_RIPPLE;
                    end
                    vdec_pkg::F6_VSUB:
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_SUB;
                    vdec_pkg::F6_VMIN:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_SUB;
                        pe_ctrl_o.output_mode = vdec_pkg::PE_OP_MODE_PASS_MIN;
                    end
                    vdec_pkg::F6_VMAX:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_SUB;
                        pe_ctrl_o.output_mode = vdec_pkg::PE_OP_MODE_PASS_MAX;
                        // vredmax
                        if (funct3 == vdec_pkg::V_OPMVV)
                            pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_RIPPLE;
                    end
                    vdec_pkg::F6_VAND:
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_AND;
                    vdec_pkg::F6_VOR:
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_OR;
                    vdec_pkg::F6_VXOR:
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_XOR;
                    vdec_pkg::F6_VWXUNARY0:
                    begin
                        // vmv.x.s returns element 0 to the core
                        wb_ctrl_o.vec_reg_write = 1'b0;
                        cfg_ctrl_o.apu_result_select = vdec_pkg::APU_RESULT_SRC_VS2_0;
                    end
                    vdec_pkg::F6_VMV:
                        wb_ctrl_o.vd_data_src = vdec_pkg::VREG_WB_SRC_SCALAR;
                    vdec_pkg::F6_VSADD:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_ADD;
                        pe_ctrl_o.saturate_mode = vdec_pkg::PE_SAT;
                    end
                    vdec_pkg::F6_VSLL_VMUL:
                    begin
                        // OPM categories select vmul
                        if (funct3 == vdec_pkg::V_OPMVV || funct3 == vdec_pkg::V_OPMVX)
                            pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_MUL;
                        else
                            pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_LSHIFT;
                    end
                    vdec_pkg::F6_VSMUL:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_MUL;
                        pe_ctrl_o.saturate_mode = vdec_pkg::PE_SAT_UPPER;
                    end
                    vdec_pkg::F6_VSRL:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_RSHIFT_LOG;
                        pe_ctrl_o.unsigned_immediate = (funct3 == vdec_pkg::V_OPIVI);
                    end
                    vdec_pkg::F6_VSRA:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_RSHIFT_AR;
                        pe_ctrl_o.unsigned_immediate = (funct3 == vdec_pkg::V_OPIVI);
                    end
                    vdec_pkg::F6_VWREDSUM:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_ADD;
                        pe_ctrl_o.operand_select = vdec_pkg::PE_OPERAND_RIPPLE;
                        pe_ctrl_o.widening = 1'b1;
                        pe_ctrl_o.wide_vs1 = 1'b1;
                    end
                    vdec_pkg::F6_VWMUL:
                    begin
                        pe_ctrl_o.pe_op = vdec_pkg::PE_ARITH_MUL;
                        pe_ctrl_o.widening = 1'b1;
                    end
                    default:
                        wb_ctrl_o.vec_reg_write = 1'b0;
                endcase

                // every register-writing instruction walks the element groups
                seq_ctrl_o.multi_cycle = wb_ctrl_o.vec_reg_write;
                seq_ctrl_o.reduction = wb_ctrl_o.vec_reg_write &&
                    (pe_ctrl_o.operand_select == vdec_pkg::PE_OPERAND_RIPPLE);
                seq_ctrl_o.fix_vd = seq_ctrl_o.reduction;
            end
        end
    end

endmodule

//--- hdl/vreg_addr_gen.sv
// element group counter and register addresses
`timescale 1ns/100ps

module vreg_addr_gen (
    input  logic clk,
    input  logic n_reset,
    input  logic exec_i,
    input  vdec_pkg::seq_ctrl_t seq_ctrl_i,
    input  logic [vdec_pkg::VREG_ADDR_W-1:0] vs1_i,
    input  logic [vdec_pkg::VREG_ADDR_W-1:0] vs2_i,
    input  logic [vdec_pkg::VREG_ADDR_W-1:0] vd_i,
    input  logic [vdec_pkg::VL_W-1:0] vl_i,
    input  logic [vdec_pkg::VSEW_W-1:0] vsew_i,
    output logic last_cycle_o,
    output logic [vdec_pkg::GROUP_W-1:0] group_o,
    output vdec_pkg::vreg_addr_t vreg_addr_o,
    output logic [1:0] elements_to_write_o
);

    logic [vdec_pkg::VL_W-1:0] vl_m1;
    logic [vdec_pkg::GROUP_W-1:0] max_group;
    logic [vdec_pkg::VREG_ADDR_W-1:0] offset;

    // groups of four, so vl of 4 still fits in one cycle
    assign vl_m1 = vl_i - 1'b1;
    assign max_group = seq_ctrl_i.multi_cycle ? vl_m1[3:2] : '0;
    assign last_cycle_o = exec_i && (group_o == max_group);

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
            group_o <= '0;
        else if (!exec_i || last_cycle_o)
            group_o <= '0;
        else
            group_o <= group_o + 1'b1;
    end

    // 16-bit elements take two registers per group
    always_comb
    begin
        if (vsew_i == vdec_pkg::SEW_16)
            offset = vdec_pkg::VREG_ADDR_W'({group_o, 1'b0});
        else
            offset = vdec_pkg::VREG_ADDR_W'(group_o);
    end

    assign vreg_addr_o.vs1 = vs1_i + offset;
    assign vreg_addr_o.vs2 = vs2_i + offset;
    assign vreg_addr_o.vd = seq_ctrl_i.fix_vd ? vd_i : vd_i + offset;

    always_comb
    begin
        elements_to_write_o = 2'd0;
        if (last_cycle_o && seq_ctrl_i.multi_cycle)
        begin
            // a reduction leaves a single element
            if (seq_ctrl_i.reduction)
                elements_to_write_o = 2'd1;
            else
                elements_to_write_o = vl_i[1:0];
        end
    end

endmodule

//--- hdl/vector_decoder.sv
// vector decoder top level
`timescale 1ns/100ps

module vector_decoder (
    input  logic clk,
    input  logic n_reset,
    input  logic apu_req_i,
    input  vdec_pkg::apu_req_t apu_data_i,
    input  logic [vdec_pkg::VL_W-1:0] vl_i,
    input  logic [vdec_pkg::VSEW_W-1:0] vsew_i,
    output logic apu_gnt_o,
    output logic apu_rvalid_o,
    output logic core_halt_o,
    output vdec_pkg::pe_ctrl_t pe_ctrl_o,
    output vdec_pkg::wb_ctrl_t wb_ctrl_o,
    output vdec_pkg::cfg_ctrl_t cfg_ctrl_o,
    output vdec_pkg::vreg_addr_t vreg_addr_o,
    output logic [vdec_pkg::GROUP_W-1:0] group_o,
    output logic [vdec_pkg::IMM_W-1:0] immediate_o,
    output logic [vdec_pkg::XLEN-1:0] scalar_a_o,
    output logic [vdec_pkg::XLEN-1:0] scalar_b_o
);

    logic exec;
    logic last_cycle;
    logic [1:0] elements_to_write;
    vdec_pkg::apu_req_t held;
    vdec_pkg::wb_ctrl_t dec_wb;
    vdec_pkg::seq_ctrl_t seq_ctrl;

    apu_sequencer u_sequencer (
        .clk          (clk),
        .n_reset      (n_reset),
        .apu_req_i    (apu_req_i),
        .apu_data_i   (apu_data_i),
        .last_cycle_i (last_cycle),
        .apu_gnt_o    (apu_gnt_o),
        .apu_rvalid_o (apu_rvalid_o),
        .core_halt_o  (core_halt_o),
        .exec_o       (exec),
        .held_o       (held)
    );

    instr_decoder u_decoder (
        .exec_i      (exec),
        .instr_i     (held.instr),
        .pe_ctrl_o   (pe_ctrl_o),
        .wb_ctrl_o   (dec_wb),
        .cfg_ctrl_o  (cfg_ctrl_o),
        .seq_ctrl_o  (seq_ctrl),
        .immediate_o (immediate_o)
    );

    vreg_addr_gen u_addr_gen (
        .clk                 (clk),
        .n_reset             (n_reset),
        .exec_i              (exec),
        .seq_ctrl_i          (seq_ctrl),
        .vs1_i               (held.instr.arith.vs1),
        .vs2_i               (held.instr.arith.vs2),
        .vd_i                (held.instr.arith.vd),
        .vl_i                (vl_i),
        .vsew_i              (vsew_i),
        .last_cycle_o        (last_cycle),
        .group_o             (group_o),
        .vreg_addr_o         (vreg_addr_o),
        .elements_to_write_o (elements_to_write)
    );

    // element count comes from the address generator
    assign wb_ctrl_o = '{
        vec_reg_write:     dec_wb.vec_reg_write,
        vd_data_src:       dec_wb.vd_data_src,
        elements_to_write: elements_to_write
    };

    assign scalar_a_o = held.scalar_a;
    assign scalar_b_o = held.scalar_b;

endmodule

//--- sim/vector_decoder_chk.sv
// handshake and sequencing assertions
`timescale 1ns/100ps

module vector_decoder_chk (
    input logic clk,
    input logic n_reset,
    input logic req_i,
    input logic gnt_i,
    input logic rvalid_i,
    input logic halt_i,
    input logic multi_cycle_i,
    input logic vec_reg_write_i,
    input logic csr_write_i,
    input logic [vdec_pkg::VL_W-1:0] vl_i
);

    int fail_count = 0;
    logic [2:0] halt_cycles;
    logic [vdec_pkg::VL_W-1:0] vl_m1;
    logic [2:0] last_index;

    // index of the final group, counted from zero
    assign vl_m1 = vl_i - 5'd1;
    assign last_index = multi_cycle_i ? {1'b0, vl_m1[3:2]} : 3'd0;

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
            halt_cycles <= '0;
        else if (halt_i)
            halt_cycles <= halt_cycles + 3'd1;
        else
            halt_cycles <= '0;
    end

    a_reset_idle: assert property (@(posedge clk)
        (!n_reset || !$past(n_reset)) |->
            (gnt_i && !halt_i && !rvalid_i && !vec_reg_write_i && !csr_write_i))
    else
    begin
        $error("outputs not idle during or right after reset");
        fail_count++;
    end

    a_gnt_halt: assert property (@(posedge clk) disable iff (!n_reset) !(gnt_i && halt_i))
    else
    begin
        $error("grant and halt high together");
        fail_count++;
    end

    a_accept: assert property (@(posedge clk) disable iff (!n_reset)
        (req_i && gnt_i) |=> (halt_i && halt_cycles == 3'd0))
    else
    begin
        $error("accepted request did not start execution");
        fail_count++;
    end

    a_rvalid_last: assert property (@(posedge clk) disable iff (!n_reset)
        halt_i |-> ((rvalid_i == (halt_cycles == last_index)) && halt_cycles <= last_index))
    else
    begin
        $error("result valid not on the last group");
        fail_count++;
    end

    a_rvalid_once: assert property (@(posedge clk) disable iff (!n_reset)
        rvalid_i |-> halt_i ##1 (!rvalid_i && !halt_i && gnt_i))
    else
    begin
        $error("result valid longer than one cycle or outside execution");
        fail_count++;
    end

endmodule

bind vector_decoder vector_decoder_chk u_chk (
    .clk             (clk),
    .n_reset         (n_reset),
    .req_i           (apu_req_i),
    .gnt_i           (apu_gnt_o),
    .rvalid_i        (apu_rvalid_o),
    .halt_i          (core_halt_o),
    .multi_cycle_i   (seq_ctrl.multi_cycle),
    .vec_reg_write_i (wb_ctrl_o.vec_reg_write),
    .csr_write_i     (cfg_ctrl_o.csr_write),
    .vl_i            (vl_i)
);

//--- sim/tb_vector_decoder.sv
// vector decoder testbench
`timescale 1ns/100ps

module tb_vector_decoder;

    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_OPS = 26;
    localparam int NUM_CFG = 3;
    localparam int NUM_INSTR = NUM_OPS + NUM_CFG;
    localparam int WATCHDOG_NS = (NUM_INSTR * 6 + RESET_CYCLES) * 2 * CLK_HALF;

    logic clk;
    logic n_reset;
    logic apu_req;
    vdec_pkg::apu_req_t apu_data;
    logic [vdec_pkg::VL_W-1:0] vl;
    logic [vdec_pkg::VSEW_W-1:0] vsew;
    logic apu_gnt;
    logic apu_rvalid;
    logic core_halt;
    vdec_pkg::pe_ctrl_t pe_ctrl;
    vdec_pkg::wb_ctrl_t wb_ctrl;
    vdec_pkg::cfg_ctrl_t cfg_ctrl;
    vdec_pkg::vreg_addr_t vreg_addr;
    logic [vdec_pkg::GROUP_W-1:0] elem_group;
    logic [vdec_pkg::IMM_W-1:0] immediate;
    logic [vdec_pkg::XLEN-1:0] scalar_a;
    logic [vdec_pkg::XLEN-1:0] scalar_b;

    logic [31:0] lfsr;
    int errors;
    int assert_errors;

    // kept instructions as {funct6, funct3}
    logic [8:0] op_list [NUM_OPS];
    logic [vdec_pkg::VL_W-1:0] vl_list [5];

    vector_decoder u_dut (
        .clk          (clk),
        .n_reset      (n_reset),
        .apu_req_i    (apu_req),
        .apu_data_i   (apu_data),
        .vl_i         (vl),
        .vsew_i       (vsew),
        .apu_gnt_o    (apu_gnt),
        .apu_rvalid_o (apu_rvalid),
        .core_halt_o  (core_halt),
        .pe_ctrl_o    (pe_ctrl),
        .wb_ctrl_o    (wb_ctrl),
        .cfg_ctrl_o   (cfg_ctrl),
        .vreg_addr_o  (vreg_addr),
        .group_o      (elem_group),
        .immediate_o  (immediate),
        .scalar_a_o   (scalar_a),
        .scalar_b_o   (scalar_b)
    );

    always #CLK_HALF clk = ~clk;

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_reduction(input logic [5:0] f6, input logic [2:0] f3);
        return (f6 == vdec_pkg::F6_VWREDSUM) || ((f3 == vdec_pkg::V_OPMVV) &&
            (f6 == vdec_pkg::F6_VADD || f6 == vdec_pkg::F6_VMAX));
    endfunction

    // processing element controls per funct6 and funct3
    function automatic vdec_pkg::pe_ctrl_t expected_pe(input logic [5:0] f6,
                                                       input logic [2:0] f3);
        vdec_pkg::pe_ctrl_t e;
        logic opm;
        e = '0;
        opm = (f3 == vdec_pkg::V_OPMVV) || (f3 == vdec_pkg::V_OPMVX);
        if (f3 == vdec_pkg::V_OPIVX || f3 == vdec_pkg::V_OPMVX)
            e.operand_select = vdec_pkg::PE_OPERAND_SCALAR;
        else if (f3 == vdec_pkg::V_OPIVI)
            e.operand_select = vdec_pkg::PE_OPERAND_IMMEDIATE;
        if (is_reduction(f6, f3))
            e.operand_select = vdec_pkg::PE_OPERAND_RIPPLE;
        case (f6)
            vdec_pkg::F6_VSUB, vdec_pkg::F6_VMIN, vdec_pkg::F6_VMAX:
                e.pe_op = vdec_pkg::PE_ARITH_SUB;
            vdec_pkg::F6_VAND:
                e.pe_op = vdec_pkg::PE_ARITH_AND;
            vdec_pkg::F6_VOR:
                e.pe_op = vdec_pkg::PE_ARITH_OR;
            vdec_pkg::F6_VXOR:
                e.pe_op = vdec_pkg::PE_ARITH_XOR;
            vdec_pkg::F6_VSLL_VMUL:
                e.pe_op = opm ? vdec_pkg::PE_ARITH_MUL : vdec_pkg::PE_ARITH_LSHIFT;
            vdec_pkg::F6_VSMUL, vdec_pkg::F6_VWMUL:
                e.pe_op = vdec_pkg::PE_ARITH_MUL;
            vdec_pkg::F6_VSRL:
                e.pe_op = vdec_pkg::PE_ARITH_RSHIFT_LOG;
            vdec_pkg::F6_VSRA:
                e.pe_op = vdec_pkg::PE_ARITH_RSHIFT_AR;
            default:
                e.pe_op = vdec_pkg::PE_ARITH_ADD;
        endcase
        if (f6 == vdec_pkg::F6_VSADD)
            e.saturate_mode = vdec_pkg::PE_SAT;
        else if (f6 == vdec_pkg::F6_VSMUL)
            e.saturate_mode = vdec_pkg::PE_SAT_UPPER;
        if (f6 == vdec_pkg::F6_VMIN)
            e.output_mode = vdec_pkg::PE_OP_MODE_PASS_MIN;
        else if (f6 == vdec_pkg::F6_VMAX)
            e.output_mode = vdec_pkg::PE_OP_MODE_PASS_MAX;
        e.widening = (f6 == vdec_pkg::F6_VWREDSUM) || (f6 == vdec_pkg::F6_VWMUL);
        e.wide_vs1 = (f6 == vdec_pkg::F6_VWREDSUM);
        e.unsigned_immediate = (f3 == vdec_pkg::V_OPIVI) &&
            (f6 == vdec_pkg::F6_VSRL || f6 == vdec_pkg::F6_VSRA);
        return e;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // issue one instruction and check every executing cycle
    task automatic run_instr(input vdec_pkg::apu_req_t req, input logic [4:0] vl_val,
                             input logic [1:0] sew);
        vdec_pkg::vinstr_arith_t a;
        vdec_pkg::pe_ctrl_t pe_exp;
        vdec_pkg::wb_ctrl_t wb_exp;
        vdec_pkg::cfg_ctrl_t cfg_exp;
        logic [10:0] imm_exp;
        logic [4:0] vl_m1;
        logic cfg_op;
        logic multi;
        logic red;
        logic done;
        int m;
        int step;
        int waited;

        a = req.instr.arith;
        cfg_op = (a.funct3 == vdec_pkg::V_OPCFG);
        red = !cfg_op && is_reduction(a.funct6, a.funct3);
        multi = !cfg_op && (a.funct6 != vdec_pkg::F6_VWXUNARY0);
        vl_m1 = vl_val - 5'd1;
        m = multi ? int'(vl_m1[3:2]) : 0;
        pe_exp = '0;
        wb_exp = '0;
        cfg_exp = '0;
        if (cfg_op)
        begin
            cfg_exp.csr_write = 1'b1;
            cfg_exp.preserve_vl = (req.instr.cfg.rs1 == 5'd0) && (req.instr.cfg.rd == 5'd0);
            cfg_exp.set_vl_max = (req.instr.cfg.rs1 == 5'd0) && (req.instr.cfg.rd != 5'd0);
            imm_exp = req.instr.cfg.zimm;
        end
        else
        begin
            pe_exp = expected_pe(a.funct6, a.funct3);
            wb_exp.vec_reg_write = multi;
            wb_exp.vd_data_src = (a.funct6 == vdec_pkg::F6_VMV) ?
                vdec_pkg::VREG_WB_SRC_SCALAR : vdec_pkg::VREG_WB_SRC_ARITH;
            cfg_exp.apu_result_select = multi ?
                vdec_pkg::APU_RESULT_SRC_VL : vdec_pkg::APU_RESULT_SRC_VS2_0;
            imm_exp = {6'd0, a.vs1};
        end

        @(posedge clk);
        #2;
        apu_data = req;
        vl = vl_val;
        vsew = sew;
        apu_req = 1'b1;
        // request stays up until a grant is seen
        waited = 0;
        @(negedge clk);
        while (!apu_gnt && waited < 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (!apu_gnt)
        begin
            $display("Error: no grant for instruction %h", req.instr);
            errors++;
            return;
        end
        @(posedge clk);
        #2;
        apu_req = 1'b0;

        done = 1'b0;
        for (int g = 0; g < 6 && !done; g++)
        begin
            @(negedge clk);
            step = (sew == vdec_pkg::SEW_16) ? 2 * g : g;
            wb_exp.elements_to_write = (multi && g == m) ? (red ? 2'd1 : vl_val[1:0]) : 2'd0;
            compare_value("group", elem_group, g);
            compare_value("halt", core_halt, 1'b1);
            compare_value("result valid", apu_rvalid, g == m);
            compare_value("vs1 address", vreg_addr.vs1, 5'(a.vs1 + step));
            compare_value("vs2 address", vreg_addr.vs2, 5'(a.vs2 + step));
            compare_value("vd address", vreg_addr.vd, red ? a.vd : 5'(a.vd + step));
            compare_value("pe_ctrl", pe_ctrl, pe_exp);
            compare_value("wb_ctrl", wb_ctrl, wb_exp);
            compare_value("cfg_ctrl", cfg_ctrl, cfg_exp);
            compare_value("immediate", immediate, imm_exp);
            compare_value("scalar a", scalar_a, req.scalar_a);
            compare_value("scalar b", scalar_b, req.scalar_b);
            done = apu_rvalid;
        end
        if (!done)
        begin
            $display("Error: result valid missing for instruction %h", req.instr);
            errors++;
        end
    endtask

    // six cycles per instruction leaves room for four groups
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        vdec_pkg::apu_req_t req;
        logic [4:0] rs1;
        logic [4:0] rd;

        lfsr = 32'h4839e973;
        errors = 0;
        clk = 1'b0;
        n_reset = 1'b0;
        apu_req = 1'b0;
        apu_data = '0;
        vl = '0;
        vsew = '0;
        vl_list = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd16};
        op_list = '{
            {vdec_pkg::F6_VADD, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VADD, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VADD, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VSUB, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VSUB, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VMIN, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VMAX, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VAND, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VOR, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VXOR, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VWXUNARY0, vdec_pkg::V_OPMVV},
            {vdec_pkg::F6_VMV, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VMV, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VSADD, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VSLL_VMUL, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VSLL_VMUL, vdec_pkg::V_OPMVV},
            {vdec_pkg::F6_VSLL_VMUL, vdec_pkg::V_OPMVX},
            {vdec_pkg::F6_VSMUL, vdec_pkg::V_OPIVX},
            {vdec_pkg::F6_VSRL, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VSRA, vdec_pkg::V_OPIVI},
            {vdec_pkg::F6_VSRA, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VADD, vdec_pkg::V_OPMVV},
            {vdec_pkg::F6_VMAX, vdec_pkg::V_OPMVV},
            {vdec_pkg::F6_VWREDSUM, vdec_pkg::V_OPIVV},
            {vdec_pkg::F6_VWMUL, vdec_pkg::V_OPMVV},
            {vdec_pkg::F6_VWMUL, vdec_pkg::V_OPMVX}
        };
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        n_reset = 1'b1;

        for (int i = 0; i < NUM_OPS; i++)
        begin
            req.instr.arith.funct6 = op_list[i][8:3];
            req.instr.arith.vm = 1'(random_bits(1));
            req.instr.arith.vs2 = 5'(random_bits(5));
            req.instr.arith.vs1 = 5'(random_bits(5));
            req.instr.arith.funct3 = op_list[i][2:0];
            req.instr.arith.vd = 5'(random_bits(5));
            req.instr.arith.opcode = vdec_pkg::V_MAJOR_OP_V;
            req.scalar_a = random_bits(32);
            req.scalar_b = random_bits(32);
            run_instr(req, vl_list[i % 5], {1'b0, 1'(random_bits(1))});
        end

        // vsetvli with both zero, rd only, and rs1 set
        for (int c = 0; c < NUM_CFG; c++)
        begin
            rs1 = (c == 2) ? {4'(random_bits(4)), 1'b1} : 5'd0;
            rd = (c == 0) ? 5'd0 : {4'(random_bits(4)), 1'b1};
            req.instr.cfg.zero = 1'b0;
            req.instr.cfg.zimm = 11'(random_bits(11));
            req.instr.cfg.rs1 = rs1;
            req.instr.cfg.funct3 = vdec_pkg::V_OPCFG;
            req.instr.cfg.rd = rd;
            req.instr.cfg.opcode = vdec_pkg::V_MAJOR_OP_V;
            req.scalar_a = random_bits(32);
            req.scalar_b = random_bits(32);
            run_instr(req, vl_list[c], {1'b0, 1'(random_bits(1))});
        end

        repeat (2) @(posedge clk);
        assert_errors = u_dut.u_chk.fail_count;
        $display("Checks done: %0d compare errors, %0d assertion errors", errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
common/vdec_pkg.sv
hdl/apu_sequencer.sv
decoder/instr_decoder.sv
hdl/vreg_addr_gen.sv
hdl/vector_decoder.sv
sim/vector_decoder_chk.sv
sim/tb_vector_decoder.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_vector_decoder
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
